//--- src.f
+incdir+common
common/l1d_arb_pkg.sv
hdl/ld_req_rr_arb.sv
hdl/st_line_fmt.sv
hdl/dtlb_resp_steer.sv
hdl/l1d_bank_input_arb.sv
sim/tb_l1d_bank_input_arb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary -j 0
TOP := tb_l1d_bank_input_arb
FILELIST := src.f
OBJDIR := obj_dir
LOG := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/tb_l1d_bank_input_arb.sv
`default_nettype none

`include "l1d_arb_macros.svh"

module tb_l1d_bank_input_arb
	import l1d_arb_pkg::*;
();

	localparam int PORTS = `L1D_LD_PORTS;
	localparam int IDLE_CYCLES = 4;
	localparam int FAIR_CYCLES = 24;
	localparam int RAND_CYCLES = 300;
	localparam int RUN_CYCLES = 3 + IDLE_CYCLES + FAIR_CYCLES + RAND_CYCLES + 3;

	logic clk = 1'b0;
	logic rst;
	ld_port_vec_t ld_vld, ld_stb_rdy, ld_rdy;
	rob_tag_t [PORTS-1:0] ld_rob_tag;
	preg_tag_t [PORTS-1:0] ld_prd;
	ldu_op_t [PORTS-1:0] ld_opcode;
	l1d_idx_t [PORTS-1:0] ld_idx;
	l1d_offset_t [PORTS-1:0] ld_offset;
	l1d_tag_t [PORTS-1:0] ld_vtag;
	ld_port_vec_t tlb_vld, tlb_excp, tlb_hit;
	ppn_t [PORTS-1:0] tlb_ppn;
	logic st_vld, st_rdy, st_bank_vld, st_bank_rdy, ld_bank_rdy, tlb_bank_rdy;
	rob_tag_t st_rob_tag, st_bank_rob_tag, bank_rob_tag;
	preg_tag_t st_prd, st_bank_prd, bank_prd;
	stu_op_t st_opcode, st_bank_opcode;
	paddr_t st_paddr, st_bank_paddr;
	xlen_data_t st_data;
	line_data_t st_bank_data;
	line_mask_t st_bank_mask;
	logic bank_vld, bank_stb_rdy, resp_vld, resp_excp, resp_hit;
	ldu_op_t bank_opcode;
	l1d_idx_t bank_idx;
	l1d_offset_t bank_offset;
	l1d_tag_t bank_vtag;
	ppn_t resp_ppn;

	integer seed = 32'h45af6334;
	int err_cnt = 0;
	int check_cnt = 0;
	int mode = 0;   // 0 idle, 1 both pipes, 2 random.
	int ref_ptr = 0;
	int ptr_next = 0;
	int prev_pipe = -1;   // pipe accepted last cycle.
	int hsk_pipe = -1;
	int grant;
	int off;
	ld_port_vec_t exp_rdy;
	ld_port_vec_t exp_hsk = '0;

	l1d_bank_input_arb u_dut (
		.clk(clk), .rst(rst),
		.ls_ld_req_vld_i(ld_vld), .ls_ld_req_rob_tag_i(ld_rob_tag),
		.ls_ld_req_prd_i(ld_prd), .ls_ld_req_opcode_i(ld_opcode),
		.ls_ld_req_idx_i(ld_idx), .ls_ld_req_offset_i(ld_offset),
		.ls_ld_req_vtag_i(ld_vtag), .stb_ld_req_rdy_i(ld_stb_rdy),
		.ls_ld_req_rdy_o(ld_rdy),
		.ls_dtlb_resp_vld_i(tlb_vld), .ls_dtlb_resp_ppn_i(tlb_ppn),
		.ls_dtlb_resp_excp_vld_i(tlb_excp), .ls_dtlb_resp_hit_i(tlb_hit),
		.ls_st_req_vld_i(st_vld), .ls_st_req_rob_tag_i(st_rob_tag),
		.ls_st_req_prd_i(st_prd), .ls_st_req_opcode_i(st_opcode),
		.ls_st_req_paddr_i(st_paddr), .ls_st_req_data_i(st_data),
		.ls_st_req_rdy_o(st_rdy),
		.l1d_ld_req_vld_o(bank_vld), .l1d_ld_req_rob_tag_o(bank_rob_tag),
		.l1d_ld_req_prd_o(bank_prd), .l1d_ld_req_opcode_o(bank_opcode),
		.l1d_ld_req_idx_o(bank_idx), .l1d_ld_req_offset_o(bank_offset),
		.l1d_ld_req_vtag_o(bank_vtag), .l1d_stb_ld_req_rdy_o(bank_stb_rdy),
		.l1d_ld_req_rdy_i(ld_bank_rdy),
		.dtlb_resp_vld_o(resp_vld), .dtlb_resp_excp_vld_o(resp_excp),
		.dtlb_resp_hit_o(resp_hit), .dtlb_resp_ppn_o(resp_ppn),
		.dtlb_resp_rdy_i(tlb_bank_rdy),
		.l1d_st_req_vld_o(st_bank_vld), .l1d_st_req_rob_tag_o(st_bank_rob_tag),
		.l1d_st_req_prd_o(st_bank_prd), .l1d_st_req_opcode_o(st_bank_opcode),
		.l1d_st_req_paddr_o(st_bank_paddr), .l1d_st_req_data_o(st_bank_data),
		.l1d_st_req_data_byte_mask_o(st_bank_mask), .l1d_st_req_rdy_i(st_bank_rdy)
	);

	always #10 clk = ~clk;

	// first requesting pipe at or after ptr, -1 when nobody requests.
	function automatic int ref_grant(input ld_port_vec_t req, input int ptr);
		int p;
		ref_grant = -1;
		for (int k = PORTS - 1; k >= 0; k--) begin
			p = (ptr + k) % PORTS;
			if (req[p])
				ref_grant = p;
		end
	endfunction

	function automatic int store_bytes(input stu_op_t op);
		case (op)
			STU_SB: store_bytes = 1;
			STU_SH: store_bytes = 2;
			STU_SW: store_bytes = 4;
			STU_SD: store_bytes = 8;
			default: store_bytes = 0;
		endcase
	endfunction

	function automatic line_mask_t ref_st_mask(input stu_op_t op, input int offs);
		ref_st_mask = '0;
		for (int i = 0; i < store_bytes(op); i++)
			if (offs + i < `LINE_BYTES)
				ref_st_mask[offs + i] = 1'b1;
	endfunction

	function automatic line_data_t ref_st_line(input stu_op_t op, input int offs,
			input xlen_data_t data);
		ref_st_line = '0;
		for (int i = 0; i < store_bytes(op); i++)
			if (offs + i < `LINE_BYTES)
				ref_st_line[(offs + i)*8 +: 8] = data[i*8 +: 8];
	endfunction

	function automatic logic [63:0] rand64();
		rand64 = {$random(seed), $random(seed)};
	endfunction

	task automatic check(input string name, input logic [511:0] got, input logic [511:0] want);
		check_cnt++;
		if (got !== want) begin
			err_cnt++;
			$display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	task automatic drive_cycle();
		for (int j = 0; j < PORTS; j++) begin
			if (mode == 0) begin
				ld_vld[j] = 1'b0;
			end else if (!(ld_vld[j] && !exp_hsk[j])) begin   // waiting loads hold.
				ld_vld[j] = (mode == 1) ? 1'b1 : 1'($random(seed));
				ld_rob_tag[j] = rob_tag_t'(rand64());
				ld_prd[j] = preg_tag_t'(rand64());
				ld_opcode[j] = ldu_op_t'(rand64());
				ld_idx[j] = l1d_idx_t'(rand64());
				ld_offset[j] = l1d_offset_t'(rand64());
				ld_vtag[j] = l1d_tag_t'(rand64());
			end
			tlb_ppn[j] = ppn_t'(rand64());
		end
		ld_stb_rdy = ld_port_vec_t'(rand64());
		ld_bank_rdy = (mode == 2) ? 1'($random(seed)) : 1'b1;
		{tlb_vld, tlb_excp, tlb_hit} = 6'(rand64());
		if (!(st_vld && !st_bank_rdy)) begin
			st_vld = 1'($random(seed));
			st_rob_tag = rob_tag_t'(rand64());
			st_prd = preg_tag_t'(rand64());
			// mostly data stores, sometimes any encoding.
			st_opcode = 1'($random(seed)) ? stu_op_t'(rand64()) : stu_op_t'(2'(rand64()));
			st_paddr = paddr_t'(rand64());
			st_data = rand64();
		end
		st_bank_rdy = 1'($random(seed));
	endtask

	// reference pointer and last handshake.
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			ref_ptr <= 0;
			prev_pipe <= -1;
		end else begin
			ref_ptr <= ptr_next;
			prev_pipe <= hsk_pipe;
		end
	end

	always @(negedge clk) begin
		grant = ref_grant(ld_vld, ref_ptr);
		exp_rdy = '0;
		exp_hsk = '0;
		hsk_pipe = -1;
		ptr_next = ref_ptr;
		if (grant >= 0) begin
			exp_rdy[grant] = ld_bank_rdy;
			exp_hsk[grant] = ld_bank_rdy;
			hsk_pipe = ld_bank_rdy ? grant : -1;
			ptr_next = (grant + 1) % PORTS;
			check("l1d_ld_req_rob_tag_o", 512'(bank_rob_tag), 512'(ld_rob_tag[grant]));
			check("l1d_ld_req_prd_o", 512'(bank_prd), 512'(ld_prd[grant]));
			check("l1d_ld_req_opcode_o", 512'(bank_opcode), 512'(ld_opcode[grant]));
			check("l1d_ld_req_idx_o", 512'(bank_idx), 512'(ld_idx[grant]));
			check("l1d_ld_req_offset_o", 512'(bank_offset), 512'(ld_offset[grant]));
			check("l1d_ld_req_vtag_o", 512'(bank_vtag), 512'(ld_vtag[grant]));
			check("l1d_stb_ld_req_rdy_o", 512'(bank_stb_rdy), 512'(ld_stb_rdy[grant]));
		end
		check("l1d_ld_req_vld_o", 512'(bank_vld), 512'(grant >= 0));
		check("ls_ld_req_rdy_o", 512'(ld_rdy), 512'(exp_rdy));
		if (prev_pipe >= 0) begin
			check("dtlb_resp_vld_o", 512'(resp_vld), 512'(tlb_vld[prev_pipe]));
			check("dtlb_resp_excp_vld_o", 512'(resp_excp), 512'(tlb_excp[prev_pipe]));
			check("dtlb_resp_hit_o", 512'(resp_hit), 512'(tlb_hit[prev_pipe]));
			check("dtlb_resp_ppn_o", 512'(resp_ppn), 512'(tlb_ppn[prev_pipe]));
		end else begin
			check("dtlb_resp_vld_o", 512'(resp_vld), '0);
			check("dtlb_resp_excp_vld_o", 512'(resp_excp), '0);
			check("dtlb_resp_hit_o", 512'(resp_hit), '0);
			check("dtlb_resp_ppn_o", 512'(resp_ppn), '0);
		end
		off = int'(st_paddr[`L1D_OFFSET_W-1:0]);
		check("l1d_st_req_vld_o", 512'(st_bank_vld), 512'(st_vld));
		check("ls_st_req_rdy_o", 512'(st_rdy), 512'(st_bank_rdy));
		check("l1d_st_req_rob_tag_o", 512'(st_bank_rob_tag), 512'(st_rob_tag));
		check("l1d_st_req_prd_o", 512'(st_bank_prd), 512'(st_prd));
		check("l1d_st_req_opcode_o", 512'(st_bank_opcode), 512'(st_opcode));
		check("l1d_st_req_paddr_o", 512'(st_bank_paddr), 512'(st_paddr));
		check("l1d_st_req_data_o", st_bank_data, ref_st_line(st_opcode, off, st_data));
		check("l1d_st_req_data_byte_mask_o", 512'(st_bank_mask),
			512'(ref_st_mask(st_opcode, off)));
	end

	initial begin
		#((RUN_CYCLES + 50) * 20);
		$display("timeout: the run did not end within the expected number of cycles");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		rst = 1'b0;
		{ld_vld, ld_stb_rdy, tlb_vld, tlb_excp, tlb_hit} = '0;
		{ld_rob_tag, ld_prd, ld_opcode, ld_idx, ld_offset, ld_vtag, tlb_ppn} = '0;
		{st_vld, st_rob_tag, st_prd, st_opcode, st_paddr, st_data} = '0;
		ld_bank_rdy = 1'b0;
		st_bank_rdy = 1'b0;
		tlb_bank_rdy = 1'b1;
		repeat (3) @(posedge clk);
		#2 rst = 1'b1;
		for (int c = 0; c < IDLE_CYCLES + FAIR_CYCLES + RAND_CYCLES; c++) begin
			@(posedge clk);
			#2;
			mode = (c < IDLE_CYCLES) ? 0 : (c < IDLE_CYCLES + FAIR_CYCLES) ? 1 : 2;
			drive_cycle();
		end
		@(posedge clk);
		@(negedge clk);
		#1;
		$display("checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/l1d_bank_input_arb.sv
`default_nettype none

`include "l1d_arb_macros.svh"

module l1d_bank_input_arb
	import l1d_arb_pkg::*;
(
	input wire logic clk,
	input wire logic rst,

	// load pipes.
	input wire ld_port_vec_t ls_ld_req_vld_i,
	input wire rob_tag_t [`L1D_LD_PORTS-1:0] ls_ld_req_rob_tag_i,
	input wire preg_tag_t [`L1D_LD_PORTS-1:0] ls_ld_req_prd_i,
	input wire ldu_op_t [`L1D_LD_PORTS-1:0] ls_ld_req_opcode_i,
	input wire l1d_idx_t [`L1D_LD_PORTS-1:0] ls_ld_req_idx_i,
	input wire l1d_offset_t [`L1D_LD_PORTS-1:0] ls_ld_req_offset_i,
	input wire l1d_tag_t [`L1D_LD_PORTS-1:0] ls_ld_req_vtag_i,
	input wire ld_port_vec_t stb_ld_req_rdy_i,
	output ld_port_vec_t ls_ld_req_rdy_o,

	// dtlb responses from the load pipes.
	input wire ld_port_vec_t ls_dtlb_resp_vld_i,
	input wire ppn_t [`L1D_LD_PORTS-1:0] ls_dtlb_resp_ppn_i,
	input wire ld_port_vec_t ls_dtlb_resp_excp_vld_i,
	input wire ld_port_vec_t ls_dtlb_resp_hit_i,

	// store pipe.
	input wire logic ls_st_req_vld_i,
	input wire rob_tag_t ls_st_req_rob_tag_i,
	input wire preg_tag_t ls_st_req_prd_i,
	input wire stu_op_t ls_st_req_opcode_i,
	input wire paddr_t ls_st_req_paddr_i,
	input wire xlen_data_t ls_st_req_data_i,
	output logic ls_st_req_rdy_o,

	// bank load request.
	output logic l1d_ld_req_vld_o,
	output rob_tag_t l1d_ld_req_rob_tag_o,
	output preg_tag_t l1d_ld_req_prd_o,
	output ldu_op_t l1d_ld_req_opcode_o,
	output l1d_idx_t l1d_ld_req_idx_o,
	output l1d_offset_t l1d_ld_req_offset_o,
	output l1d_tag_t l1d_ld_req_vtag_o,
	output logic l1d_stb_ld_req_rdy_o,
	input wire logic l1d_ld_req_rdy_i,

	// bank dtlb response.
	output logic dtlb_resp_vld_o,
	output logic dtlb_resp_excp_vld_o,
	output logic dtlb_resp_hit_o,
	output ppn_t dtlb_resp_ppn_o,
	input wire logic dtlb_resp_rdy_i,   // bank always takes the response.

	// bank store request.
	output logic l1d_st_req_vld_o,
	output rob_tag_t l1d_st_req_rob_tag_o,
	output preg_tag_t l1d_st_req_prd_o,
	output stu_op_t l1d_st_req_opcode_o,
	output paddr_t l1d_st_req_paddr_o,
	output line_data_t l1d_st_req_data_o,
	output line_mask_t l1d_st_req_data_byte_mask_o,
	input wire logic l1d_st_req_rdy_i
);

	ld_port_vec_t ld_hsk;

	ld_req_rr_arb u_ld_arb (
		.clk(clk),
		.rst(rst),
		.req_vld_i(ls_ld_req_vld_i),
		.req_rob_tag_i(ls_ld_req_rob_tag_i),
		.req_prd_i(ls_ld_req_prd_i),
		.req_opcode_i(ls_ld_req_opcode_i),
		.req_idx_i(ls_ld_req_idx_i),
		.req_offset_i(ls_ld_req_offset_i),
		.req_vtag_i(ls_ld_req_vtag_i),
		.stb_rdy_i(stb_ld_req_rdy_i),
		.bank_rdy_i(l1d_ld_req_rdy_i),
		.req_rdy_o(ls_ld_req_rdy_o),
		.bank_vld_o(l1d_ld_req_vld_o),
		.bank_rob_tag_o(l1d_ld_req_rob_tag_o),
		.bank_prd_o(l1d_ld_req_prd_o),
		.bank_opcode_o(l1d_ld_req_opcode_o),
		.bank_idx_o(l1d_ld_req_idx_o),
		.bank_offset_o(l1d_ld_req_offset_o),
		.bank_vtag_o(l1d_ld_req_vtag_o),
		.bank_stb_rdy_o(l1d_stb_ld_req_rdy_o),
		.hsk_o(ld_hsk)
	);

	// single store port, so no arbitration.
	assign l1d_st_req_vld_o = ls_st_req_vld_i;
	assign ls_st_req_rdy_o = l1d_st_req_rdy_i;
	assign l1d_st_req_rob_tag_o = ls_st_req_rob_tag_i;
	assign l1d_st_req_prd_o = ls_st_req_prd_i;
	assign l1d_st_req_opcode_o = ls_st_req_opcode_i;
	assign l1d_st_req_paddr_o = ls_st_req_paddr_i;

	st_line_fmt u_st_fmt (
		.st_opcode_i(ls_st_req_opcode_i),
		.st_offset_i(ls_st_req_paddr_i[`L1D_OFFSET_W-1:0]),
		.st_data_i(ls_st_req_data_i),
		.line_data_o(l1d_st_req_data_o),
		.line_mask_o(l1d_st_req_data_byte_mask_o)
	);

	dtlb_resp_steer u_dtlb_steer (
		.clk(clk),
		.rst(rst),
		.hsk_i(ld_hsk),
		.tlb_vld_i(ls_dtlb_resp_vld_i),
		.tlb_excp_i(ls_dtlb_resp_excp_vld_i),
		.tlb_hit_i(ls_dtlb_resp_hit_i),
		.tlb_ppn_i(ls_dtlb_resp_ppn_i),
		.resp_vld_o(dtlb_resp_vld_o),
		.resp_excp_o(dtlb_resp_excp_vld_o),
		.resp_hit_o(dtlb_resp_hit_o),
		.resp_ppn_o(dtlb_resp_ppn_o)
	);

endmodule

`default_nettype wire

//--- hdl/dtlb_resp_steer.sv
`default_nettype none

`include "l1d_arb_macros.svh"

module dtlb_resp_steer
	import l1d_arb_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire ld_port_vec_t hsk_i,
	input wire ld_port_vec_t tlb_vld_i,
	input wire ld_port_vec_t tlb_excp_i,
	input wire ld_port_vec_t tlb_hit_i,
	input wire ppn_t [`L1D_LD_PORTS-1:0] tlb_ppn_i,
	output logic resp_vld_o,
	output logic resp_excp_o,
	output logic resp_hit_o,
	output ppn_t resp_ppn_o
);

	ld_port_vec_t hsk_q;   // pipe accepted last cycle, one-hot.

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			hsk_q <= '0;
		else
			hsk_q <= hsk_i;
	end

	// translation for the load arrives a cycle behind its request.
	always_comb begin
		resp_vld_o = 1'b0;
		resp_excp_o = 1'b0;
		resp_hit_o = 1'b0;
		resp_ppn_o = '0;
		for (int j = 0; j < `L1D_LD_PORTS; j++) begin
			if (hsk_q[j]) begin
				resp_vld_o = tlb_vld_i[j];
				resp_excp_o = tlb_excp_i[j];
				resp_hit_o = tlb_hit_i[j];
				resp_ppn_o = tlb_ppn_i[j];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/st_line_fmt.sv
`default_nettype none

`include "l1d_arb_macros.svh"

module st_line_fmt
	import l1d_arb_pkg::*;
(
	input wire stu_op_t st_opcode_i,
	input wire l1d_offset_t st_offset_i,
	input wire xlen_data_t st_data_i,
	output line_data_t line_data_o,
	output line_mask_t line_mask_o
);

	localparam int XLEN_BYTES = `XLEN / 8;

	logic [3:0] st_bytes;
	logic [XLEN_BYTES-1:0] size_mask;
	xlen_data_t data_keep;
	xlen_data_t data_sized;
	logic [$clog2(`LINE_W)-1:0] bit_shift;

	// store size in bytes.
	always_comb begin
		case (st_opcode_i)
			STU_SB: st_bytes = 4'd1;
			STU_SH: st_bytes = 4'd2;
			STU_SW: st_bytes = 4'd4;
			STU_SD: st_bytes = 4'd8;
			default: st_bytes = 4'd0;   // no data, empty mask.
		endcase
	end

	assign size_mask = XLEN_BYTES'((16'd1 << st_bytes) - 16'd1);

	// clear the bytes above the store size.
	always_comb begin
		for (int i = 0; i < XLEN_BYTES; i++)
			data_keep[i*8 +: 8] = {8{size_mask[i]}};
	end

	assign data_sized = st_data_i & data_keep;

	assign bit_shift = {st_offset_i, 3'b000};

	// anything shifted past byte 63 falls off the line.
	assign line_mask_o = line_mask_t'(size_mask) << st_offset_i;
	assign line_data_o = line_data_t'(data_sized) << bit_shift;

endmodule

`default_nettype wire

//--- hdl/ld_req_rr_arb.sv
`default_nettype none

`include "l1d_arb_macros.svh"

module ld_req_rr_arb
	import l1d_arb_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire ld_port_vec_t req_vld_i,
	input wire rob_tag_t [`L1D_LD_PORTS-1:0] req_rob_tag_i,
	input wire preg_tag_t [`L1D_LD_PORTS-1:0] req_prd_i,
	input wire ldu_op_t [`L1D_LD_PORTS-1:0] req_opcode_i,
	input wire l1d_idx_t [`L1D_LD_PORTS-1:0] req_idx_i,
	input wire l1d_offset_t [`L1D_LD_PORTS-1:0] req_offset_i,
	input wire l1d_tag_t [`L1D_LD_PORTS-1:0] req_vtag_i,
	input wire ld_port_vec_t stb_rdy_i,
	input wire logic bank_rdy_i,
	output ld_port_vec_t req_rdy_o,
	output logic bank_vld_o,
	output rob_tag_t bank_rob_tag_o,
	output preg_tag_t bank_prd_o,
	output ldu_op_t bank_opcode_o,
	output l1d_idx_t bank_idx_o,
	output l1d_offset_t bank_offset_o,
	output l1d_tag_t bank_vtag_o,
	output logic bank_stb_rdy_o,
	output ld_port_vec_t hsk_o
);

	ld_port_idx_t rr_ptr;      // highest priority pipe.
	ld_port_idx_t grant_idx;
	ld_port_idx_t next_ptr;
	ld_port_vec_t grant;
	logic any_req;

	assign any_req = |req_vld_i;

	// first requester at or after the pointer, in circular order.
	always_comb begin
		int cand;
		logic found;
		found = 1'b0;
		grant_idx = rr_ptr;
		for (int k = 0; k < `L1D_LD_PORTS; k++) begin
			cand = int'(rr_ptr) + k;
			if (cand >= `L1D_LD_PORTS)
				cand = cand - `L1D_LD_PORTS;
			if (!found && req_vld_i[cand]) begin
				found = 1'b1;
				grant_idx = ld_port_idx_t'(cand);
			end
		end
		grant = found ? (ld_port_vec_t'(1) << grant_idx) : '0;
	end

	assign next_ptr = (grant_idx == ld_port_idx_t'(`L1D_LD_PORTS - 1)) ?
		'0 : ld_port_idx_t'(grant_idx + 1'b1);

	// rotates on any request, accepted or not.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			rr_ptr <= '0;
		else if (any_req)
			rr_ptr <= next_ptr;
	end

	assign bank_vld_o = any_req;
	assign bank_rob_tag_o = req_rob_tag_i[grant_idx];
	assign bank_prd_o = req_prd_i[grant_idx];
	assign bank_opcode_o = req_opcode_i[grant_idx];
	assign bank_idx_o = req_idx_i[grant_idx];
	assign bank_offset_o = req_offset_i[grant_idx];
	assign bank_vtag_o = req_vtag_i[grant_idx];
	assign bank_stb_rdy_o = stb_rdy_i[grant_idx];

	assign req_rdy_o = grant & {`L1D_LD_PORTS{bank_rdy_i}};   // losers never see ready.
	assign hsk_o = req_rdy_o & req_vld_i;

endmodule

`default_nettype wire

//--- common/l1d_arb_pkg.sv
`default_nettype none

`include "l1d_arb_macros.svh"

package l1d_arb_pkg;

	typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [`PREG_TAG_W-1:0] preg_tag_t;
	typedef logic [`LDU_OP_W-1:0] ldu_op_t;
	typedef logic [`STU_OP_W-1:0] stu_op_t;

	typedef logic [`L1D_IDX_W-1:0] l1d_idx_t;
	typedef logic [`L1D_OFFSET_W-1:0] l1d_offset_t;
	typedef logic [`L1D_TAG_W-1:0] l1d_tag_t;   // virtual tag of a load.
	typedef logic [`PADDR_W-1:0] paddr_t;
	typedef logic [`PPN_W-1:0] ppn_t;

	typedef logic [`XLEN-1:0] xlen_data_t;
	typedef logic [`LINE_W-1:0] line_data_t;
	typedef logic [`LINE_BYTES-1:0] line_mask_t;

	// one bit per load pipe, and a pipe number.
	typedef logic [`L1D_LD_PORTS-1:0] ld_port_vec_t;
	typedef logic [$clog2(`L1D_LD_PORTS)-1:0] ld_port_idx_t;

	// data store opcodes, sizes 1, 2, 4 and 8 bytes.
	// other encodings (amo, cache ops) carry no store data.
	typedef enum logic [`STU_OP_W-1:0] {
		STU_SB = `STU_OP_W'(0),
		STU_SH = `STU_OP_W'(1),
		STU_SW = `STU_OP_W'(2),
		STU_SD = `STU_OP_W'(3)
	} stu_op_e;

endpackage

`default_nettype wire

//--- common/l1d_arb_macros.svh
`ifndef L1D_ARB_MACROS_SVH
`define L1D_ARB_MACROS_SVH

// load pipes feeding the bank.
`define L1D_LD_PORTS 2

// instruction side tags and opcodes.
`define ROB_TAG_W 4
`define PREG_TAG_W 6
`define LDU_OP_W 3
`define STU_OP_W 5

// 64 sets of 64 byte lines.
`define L1D_IDX_W 6
`define L1D_OFFSET_W 6

`define PADDR_W 56
`define L1D_TAG_W (`PADDR_W - `L1D_IDX_W - `L1D_OFFSET_W)
`define PPN_W 44

`define XLEN 64

// one cache line and its byte enables.
`define LINE_W 512
`define LINE_BYTES 64

`endif
